//--- hdl/cpu_params.svh
// Core-wide sizing macros
//   Data and address width, register file size,
//   register address width and the reset fetch address
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and address width in bits
`define CPU_XLEN 32

// Architectural integer registers, x0 included
`define CPU_NUM_REGS 32

// Bits needed to name one register
`define CPU_REG_AW 5

// First fetch after reset release
`define CPU_RESET_PC 32'h0000_8000

`endif

//--- hdl/cpu_pkg.sv
// Shared types of the multi-cycle core
//   Sequencer steps, RISC-V major opcodes,
//   ALU operation codes and the flags record
package cpu_pkg;

    // --------------------
    // Sequencer steps
    // --------------------
    typedef enum logic [2:0] {
        STEP_FETCH     = 3'd0,
        STEP_DECODE    = 3'd1,
        STEP_EXECUTE   = 3'd2,
        STEP_MEMORY    = 3'd3,
        STEP_WRITEBACK = 3'd4
    } step_t;

    // --------------------
    // Major opcodes, bits 6:0 of the instruction
    // --------------------
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'h03,
        OPC_OP_IMM = 7'h13,
        OPC_AUIPC  = 7'h17,
        OPC_STORE  = 7'h23,
        OPC_OP     = 7'h33,
        OPC_LUI    = 7'h37,
        OPC_BRANCH = 7'h63,
        OPC_JALR   = 7'h67,
        OPC_JAL    = 7'h6F,
        OPC_SYSTEM = 7'h73
    } opcode_t;

    // --------------------
    // ALU operations
    // --------------------
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    // Comparison of operand a against operand b
    // c unsigned less, z equal, n signed less, v overflow of a - b
    typedef struct packed {
        logic c;
        logic z;
        logic n;
        logic v;
    } flags_t;

endpackage

//--- hdl/cpu_decoder.sv
// Instruction decoder
//   Field extraction, immediate generation per format,
//   ALU operation select and instruction class flags
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_decoder (
    input  logic [`CPU_XLEN-1:0]   instr,
    output cpu_pkg::opcode_t       opcode,
    output logic [2:0]             funct3,
    output logic [`CPU_REG_AW-1:0] rd,
    output logic [`CPU_REG_AW-1:0] rs1,
    output logic [`CPU_REG_AW-1:0] rs2,
    output logic [`CPU_XLEN-1:0]   imm,
    output cpu_pkg::alu_op_t       alu_op,
    output logic                   use_pc_a,
    output logic                   use_imm_b,
    output logic                   is_load,
    output logic                   is_store,
    output logic                   is_branch,
    output logic                   is_jump,
    output logic                   writes_rd,
    output logic                   is_halt
);
    import cpu_pkg::*;

    logic   rd_class;
    // funct7 bit 5 picks SUB and SRA
    logic   alt;

    // --------------------
    // Fixed fields
    // --------------------
    assign opcode = opcode_t'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign alt    = instr[30];

    // Sign-extended immediate, format chosen by opcode
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            OPC_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {instr[31:12], 12'h000};
            OPC_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // --------------------
    // ALU operation
    // --------------------
    always_comb begin
        // Address and link arithmetic all add
        alu_op = ALU_ADD;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110: alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            // Branch compares rs1 with rs2, flags carry the outcome
            OPC_BRANCH: alu_op = ALU_SUB;
            OPC_LUI:    alu_op = ALU_PASS_B;
            default:    alu_op = ALU_ADD;
        endcase
    end

    // --------------------
    // Class and operand flags
    // --------------------
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jump   = (opcode == OPC_JAL) || (opcode == OPC_JALR);

    // JAL target is pc + imm through the ALU
    assign use_pc_a  = (opcode == OPC_AUIPC) || (opcode == OPC_JAL);
    assign use_imm_b = !((opcode == OPC_OP) || (opcode == OPC_BRANCH));

    assign rd_class  = (opcode == OPC_OP) || (opcode == OPC_OP_IMM) || is_load || is_jump
                       || (opcode == OPC_LUI) || (opcode == OPC_AUIPC);
    // x0 destination suppressed here
    assign writes_rd = rd_class && (rd != '0);

    // EBREAK, imm field 1 under SYSTEM with funct3 zero
    assign is_halt   = (opcode == OPC_SYSTEM) && (funct3 == 3'b000)
                       && (instr[31:20] == 12'h001);

endmodule

//--- hdl/cpu_alu.sv
// Integer ALU
//   Add, subtract, logic, shifts and set-less-than,
//   plus comparison flags of a against b
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_alu (
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  cpu_pkg::alu_op_t     op,
    output logic [`CPU_XLEN-1:0] result,
    output cpu_pkg::flags_t      flags
);
    import cpu_pkg::*;

    // One extra bit keeps the borrow of a - b
    logic [`CPU_XLEN:0]   diff;
    logic [4:0]           shamt;
    logic                 lt_signed;
    logic                 lt_unsigned;

    assign diff  = {1'b0, a} - {1'b0, b};
    assign shamt = b[4:0];

    // --------------------
    // Comparison
    // --------------------
    assign lt_unsigned = diff[`CPU_XLEN];
    assign lt_signed   = $signed(a) < $signed(b);

    assign flags.c = lt_unsigned;
    assign flags.z = (a == b);
    assign flags.n = lt_signed;
    // Operand signs differ and result sign differs from a
    assign flags.v = (a[`CPU_XLEN-1] ^ b[`CPU_XLEN-1])
                     & (a[`CPU_XLEN-1] ^ diff[`CPU_XLEN-1]);

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = diff[`CPU_XLEN-1:0];
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_SLT:    result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            // LUI immediate straight through
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

//--- hdl/cpu_regfile.sv
// Integer register file
//   Two combinational read ports, one clocked write port,
//   x0 reads as zero and has no storage
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_REG_AW-1:0] rs1_addr,
    input  logic [`CPU_REG_AW-1:0] rs2_addr,
    output logic [`CPU_XLEN-1:0]   rs1_data,
    output logic [`CPU_XLEN-1:0]   rs2_data,
    input  logic                   wb_en,
    input  logic [`CPU_REG_AW-1:0] wb_addr,
    input  logic [`CPU_XLEN-1:0]   wb_data
);

    // x1 .. x31 only
    logic [`CPU_XLEN-1:0] regs [1:`CPU_NUM_REGS-1];

    // Decoder never raises wb_en for x0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Read ports
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/cpu_load_align.sv
// Load data alignment
//   Byte or halfword pick from the loaded word,
//   then sign or zero extension by funct3
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_load_align (
    input  logic [`CPU_XLEN-1:0] word,
    input  logic [1:0]           offset,
    input  logic [2:0]           funct3,
    output logic [`CPU_XLEN-1:0] data
);

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // Little endian, offset counts bytes
    assign byte_val = word[8*offset +: 8];
    assign half_val = offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (funct3)
            F3_LB:   data = {{24{byte_val[7]}}, byte_val};
            F3_LH:   data = {{16{half_val[15]}}, half_val};
            F3_LBU:  data = {24'h000000, byte_val};
            F3_LHU:  data = {16'h0000, half_val};
            // LW and anything else pass the word
            default: data = word;
        endcase
    end

endmodule

//--- hdl/cpu_sequencer.sv
// Step sequencer of the multi-cycle core
//   Fetch / decode / execute / memory / writeback FSM, PC,
//   instruction and result registers, flags, memory strobes,
//   ALU operand select and writeback select
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    // Memory side
    input  logic                   mem_ready,
    input  logic [`CPU_XLEN-1:0]   mem_rdata,
    output logic [`CPU_XLEN-1:0]   mem_addr,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic [`CPU_XLEN-1:0]   mem_wdata,
    output logic                   halted,
    output cpu_pkg::flags_t        cpu_flags,
    // Decoder
    output logic [`CPU_XLEN-1:0]   instr,
    input  cpu_pkg::opcode_t       opcode,
    input  logic [2:0]             funct3,
    input  logic [`CPU_REG_AW-1:0] rd,
    input  logic [`CPU_XLEN-1:0]   imm,
    input  logic                   use_pc_a,
    input  logic                   use_imm_b,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic                   is_branch,
    input  logic                   is_jump,
    input  logic                   writes_rd,
    input  logic                   is_halt,
    // Register file read data
    input  logic [`CPU_XLEN-1:0]   rs1_data,
    input  logic [`CPU_XLEN-1:0]   rs2_data,
    // ALU
    output logic [`CPU_XLEN-1:0]   alu_a,
    output logic [`CPU_XLEN-1:0]   alu_b,
    input  logic [`CPU_XLEN-1:0]   alu_result,
    input  cpu_pkg::flags_t        alu_flags,
    // Load alignment
    output logic [`CPU_XLEN-1:0]   load_word,
    output logic [1:0]             load_offset,
    input  logic [`CPU_XLEN-1:0]   load_data,
    // Register file write port
    output logic                   wb_en,
    output logic [`CPU_REG_AW-1:0] wb_addr,
    output logic [`CPU_XLEN-1:0]   wb_data
);
    import cpu_pkg::*;

    step_t                step;
    logic [`CPU_XLEN-1:0] pc_reg;
    logic [`CPU_XLEN-1:0] ir_reg;
    logic [`CPU_XLEN-1:0] result_reg;
    logic [`CPU_XLEN-1:0] load_reg;
    flags_t               flags_reg;
    logic                 halted_reg;
    // pc_reg moves past the instruction at fetch
    logic [`CPU_XLEN-1:0] cur_pc;
    logic                 mem_access;
    logic                 taken;

    assign cur_pc     = pc_reg - 32'd4;
    assign mem_access = is_load || is_store;

    // Branch condition from the rs1 - rs2 compare
    always_comb begin
        case (funct3)
            3'b000:  taken = alu_flags.z;
            3'b001:  taken = !alu_flags.z;
            3'b100:  taken = alu_flags.n;
            3'b101:  taken = !alu_flags.n;
            3'b110:  taken = alu_flags.c;
            3'b111:  taken = !alu_flags.c;
            default: taken = 1'b0;
        endcase
    end

    // --------------------
    // Control state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step       <= STEP_FETCH;
            pc_reg     <= `CPU_RESET_PC;
            flags_reg  <= '0;
            halted_reg <= 1'b0;
        end else if (!halted_reg) begin
            case (step)
                // Wait cycles hold the step
                STEP_FETCH: begin
                    if (mem_ready) begin
                        pc_reg <= pc_reg + 32'd4;
                        step   <= STEP_DECODE;
                    end
                end
                STEP_DECODE: step <= STEP_EXECUTE;
                STEP_EXECUTE: begin
                    if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
                        flags_reg <= alu_flags;
                    end
                    if (is_branch && taken) begin
                        pc_reg <= cur_pc + imm;
                    end else if (is_jump) begin
                        // JALR target drops bit 0
                        pc_reg <= {alu_result[`CPU_XLEN-1:1], 1'b0};
                    end
                    halted_reg <= is_halt;
                    step       <= mem_access ? STEP_MEMORY : STEP_WRITEBACK;
                end
                STEP_MEMORY: begin
                    if (mem_ready) begin
                        step <= STEP_WRITEBACK;
                    end
                end
                default: step <= STEP_FETCH;
            endcase
        end
    end

    // --------------------
    // Payload registers
    // --------------------
    always_ff @(posedge clk) begin
        if (step == STEP_FETCH && mem_ready) begin
            ir_reg <= mem_rdata;
        end
        // Link address for jumps, otherwise the ALU result or data address
        if (step == STEP_EXECUTE) begin
            result_reg <= is_jump ? pc_reg : alu_result;
        end
        if (step == STEP_MEMORY && is_load && mem_ready) begin
            load_reg <= mem_rdata;
        end
    end

    // --------------------
    // Memory strobes
    // --------------------
    // Halt freezes the FSM in writeback, so both strobes stay low
    assign mem_read  = (step == STEP_FETCH) || (step == STEP_MEMORY && is_load);
    assign mem_write = (step == STEP_MEMORY) && is_store;
    assign mem_addr  = (step == STEP_MEMORY) ? result_reg : pc_reg;
    // rs2 read stays stable, the instruction register is held
    assign mem_wdata = rs2_data;

    // ALU operands
    assign alu_a = use_pc_a ? cur_pc : rs1_data;
    assign alu_b = use_imm_b ? imm : rs2_data;

    assign load_word   = load_reg;
    assign load_offset = result_reg[1:0];

    // --------------------
    // Writeback select
    // --------------------
    assign wb_en   = (step == STEP_WRITEBACK) && writes_rd;
    assign wb_addr = rd;
    // Loads take the aligned word, the rest the result register
    assign wb_data = is_load ? load_data : result_reg;

    assign instr     = ir_reg;
    assign halted    = halted_reg;
    assign cpu_flags = flags_reg;

endmodule

//--- hdl/cpu_core.sv
// Multi-cycle RV32I core, top level
//   Sequencer, decoder, ALU, register file and load
//   alignment joined by wires
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic [`CPU_XLEN-1:0] mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [`CPU_XLEN-1:0] mem_wdata,
    input  logic [`CPU_XLEN-1:0] mem_rdata,
    input  logic                 mem_ready,
    output logic                 halted,
    output cpu_pkg::flags_t      cpu_flags
);
    import cpu_pkg::*;

    // Decoder outputs
    logic [`CPU_XLEN-1:0]   instr;
    opcode_t                opcode;
    logic [2:0]             funct3;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_REG_AW-1:0] rs1;
    logic [`CPU_REG_AW-1:0] rs2;
    logic [`CPU_XLEN-1:0]   imm;
    alu_op_t                alu_op;
    logic                   use_pc_a;
    logic                   use_imm_b;
    logic                   is_load;
    logic                   is_store;
    logic                   is_branch;
    logic                   is_jump;
    logic                   writes_rd;
    logic                   is_halt;

    // Datapath
    logic [`CPU_XLEN-1:0]   rs1_data;
    logic [`CPU_XLEN-1:0]   rs2_data;
    logic [`CPU_XLEN-1:0]   alu_a;
    logic [`CPU_XLEN-1:0]   alu_b;
    logic [`CPU_XLEN-1:0]   alu_result;
    flags_t                 alu_flags;
    logic [`CPU_XLEN-1:0]   load_word;
    logic [1:0]             load_offset;
    logic [`CPU_XLEN-1:0]   load_data;
    logic                   wb_en;
    logic [`CPU_REG_AW-1:0] wb_addr;
    logic [`CPU_XLEN-1:0]   wb_data;

    // --------------------
    // Control
    // --------------------
    cpu_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_wdata   (mem_wdata),
        .halted      (halted),
        .cpu_flags   (cpu_flags),
        .instr       (instr),
        .opcode      (opcode),
        .funct3      (funct3),
        .rd          (rd),
        .imm         (imm),
        .use_pc_a    (use_pc_a),
        .use_imm_b   (use_imm_b),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .writes_rd   (writes_rd),
        .is_halt     (is_halt),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .load_word   (load_word),
        .load_offset (load_offset),
        .load_data   (load_data),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    cpu_decoder u_decoder (
        .instr     (instr),
        .opcode    (opcode),
        .funct3    (funct3),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_pc_a  (use_pc_a),
        .use_imm_b (use_imm_b),
        .is_load   (is_load),
        .is_store  (is_store),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .writes_rd (writes_rd),
        .is_halt   (is_halt)
    );

    // --------------------
    // Datapath
    // --------------------
    cpu_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    // Register numbers come straight from the decoder
    cpu_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    cpu_load_align u_load_align (
        .word   (load_word),
        .offset (load_offset),
        .funct3 (funct3),
        .data   (load_data)
    );

endmodule

//--- verification/cpu_core_assert.sv
// Concurrent checks on the core's memory interface
//   Strobe exclusion, request stability under wait,
//   halt hold and no strobes while halted; bind to cpu_core
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic [`CPU_XLEN-1:0] mem_addr,
    input logic                 mem_read,
    input logic                 mem_write,
    input logic [`CPU_XLEN-1:0] mem_wdata,
    input logic                 mem_ready,
    input logic                 halted
);

    // Read and write strobes are exclusive
    strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("read and write strobes high together");

    // --------------------
    // Waiting requests hold still
    // --------------------
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) && !mem_ready |=>
            $stable(mem_addr) && $stable(mem_read) && $stable(mem_write))
        else $error("request changed while waiting for mem_ready");

    wdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write && !mem_ready |=> $stable(mem_wdata))
        else $error("write data changed while waiting for mem_ready");

    // Halt is sticky until reset
    halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted fell without reset");

    halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !mem_read && !mem_write)
        else $error("memory strobe while halted");

endmodule

bind cpu_core cpu_core_assert u_core_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .halted    (halted)
);

//--- verification/cpu_core_tb.sv
// Testbench of the multi-cycle core
//   Clock, reset, word memory with random mem_ready,
//   pattern file reader, store and flag checks, report
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int    MEM_WORDS    = 16384;
    localparam string PATTERN_FILE = "verification/cpu_core_patterns.hex";

    logic                 clk;
    logic                 rst_n;
    logic [`CPU_XLEN-1:0] mem_addr;
    logic                 mem_read;
    logic                 mem_write;
    logic [`CPU_XLEN-1:0] mem_wdata;
    logic [`CPU_XLEN-1:0] mem_rdata;
    logic                 mem_ready;
    logic                 halted;
    flags_t               cpu_flags;

    // 64 KB of words, indexed by address bits 15:2
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];

    int test_errors;
    int passed_tests;
    int failed_tests;
    int test_num;
    int prog_words;

    cpu_core dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .halted    (halted),
        .cpu_flags (cpu_flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Background pattern, upper half is the inverted address
    task automatic fill_memory();
        logic [15:0] addr_lo;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr_lo = 16'(i * 4);
            mem[i] = {~addr_lo, addr_lo};
        end
    endtask

    // Compare one completed store with the next expected one
    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] ea;
        logic [31:0] ed;
        assert (exp_addr_q.size() > 0) else begin
            $display("Unexpected store of %h to %h", data, addr);
            test_errors++;
        end
        if (exp_addr_q.size() > 0) begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            assert (addr == ea) else begin
                $display("Fail mem_addr expected %h got %h", ea, addr);
                test_errors++;
            end
            assert (data == ed) else begin
                $display("Fail mem_wdata expected %h got %h", ed, data);
                test_errors++;
            end
        end
    endtask

    // --------------------
    // Memory model
    // --------------------
    // Ready chosen per cycle, the transfer completes at the next rising edge
    initial begin : mem_model
        logic ready;
        void'($urandom(32'hf206_eef5));
        forever begin
            @(negedge clk);
            ready = ($urandom % 4) != 0;
            mem_ready = ready;
            if (ready && mem_read) begin
                mem_rdata = mem[mem_addr[15:2]];
            end
            if (ready && mem_write && rst_n) begin
                mem[mem_addr[15:2]] = mem_wdata;
                check_store(mem_addr, mem_wdata);
            end
        end
    end

    // Reset, run to halt, then check the quiet period and the end state
    task automatic run_test(input logic [3:0] exp_flags, output bit timed_out);
        int limit;
        int cycles;
        limit = 40 * prog_words + 200;
        cycles = 0;
        test_errors = 0;
        timed_out = 1'b0;
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Test %0d: core did not halt within %0d cycles", test_num, limit);
            timed_out = 1'b1;
            failed_tests++;
        end else begin
            repeat (20) begin
                @(negedge clk);
                assert (!mem_read && !mem_write) else begin
                    $display("Memory strobe after halt at address %h", mem_addr);
                    test_errors++;
                end
            end
            assert (halted) else begin
                $display("halted dropped after EBREAK");
                test_errors++;
            end
            assert (cpu_flags == exp_flags) else begin
                $display("Fail cpu_flags expected %h got %h", exp_flags, cpu_flags);
                test_errors++;
            end
            assert (exp_addr_q.size() == 0) else begin
                $display("%0d expected stores never happened", exp_addr_q.size());
                test_errors++;
            end
            if (test_errors == 0) begin
                passed_tests++;
            end else begin
                failed_tests++;
            end
            $display("Test %0d: %s, %0d words, %0d cycles, %0d errors", test_num,
                     (test_errors == 0) ? "pass" : "fail", prog_words, cycles, test_errors);
        end
    endtask

    // --------------------
    // Pattern file driver
    // --------------------
    initial begin : main
        int          fd;
        int          rc;
        int          kind;
        logic [31:0] addr;
        logic [31:0] val;
        string       line;
        bit          timed_out;
        bit          file_ok;
        rst_n = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        passed_tests = 0;
        failed_tests = 0;
        test_num = 0;
        prog_words = 0;
        timed_out = 1'b0;
        fill_memory();
        fd = $fopen(PATTERN_FILE, "r");
        file_ok = (fd != 0);
        if (!file_ok) begin
            $display("Cannot open pattern file %s", PATTERN_FILE);
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                rc = $fgets(line, fd);
                rc = $sscanf(line, "%d %h %h", kind, addr, val);
                // Comment and blank lines give fewer than three fields
                if (rc == 3) begin
                    case (kind)
                        0: begin
                            mem[addr[15:2]] = val;
                            prog_words++;
                        end
                        1: begin
                            exp_addr_q.push_back(addr);
                            exp_data_q.push_back(val);
                        end
                        2: begin
                            test_num++;
                            run_test(val[3:0], timed_out);
                            exp_addr_q.delete();
                            exp_data_q.delete();
                            fill_memory();
                            prog_words = 0;
                        end
                        default: begin
                            $display("Unknown pattern kind %0d", kind);
                            failed_tests++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        $display("Tests run %0d, passed %0d, failed %0d", test_num, passed_tests, failed_tests);
        if (file_ok && !timed_out && failed_tests == 0 && test_num > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- cpu_core.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_decoder.sv
hdl/cpu_alu.sv
hdl/cpu_regfile.sv
hdl/cpu_load_align.sv
hdl/cpu_sequencer.sv
hdl/cpu_core.sv
verification/cpu_core_assert.sv
verification/cpu_core_tb.sv

//--- Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/cpu_core_patterns.hex
// kind addr value: 0 memory word, 1 expected store (address, data) in order,
// 2 end of test with value = expected cpu_flags {c,z,n,v}
// Test 1: ALU register and immediate operations
0 00008000 000090b7
0 00008004 06400113
0 00008008 ff900193
0 0000800c 00310233
0 00008010 0040a023
0 00008014 403102b3
0 00008018 0050a223
0 0000801c 4011d313
0 00008020 0060a423
0 00008024 003133b3
0 00008028 0070a623
0 0000802c 0f014413
0 00008030 0080a823
0 00008034 0021a4b3
0 00008038 0090aa23
0 0000803c 00100073
1 00009000 0000005d
1 00009004 0000006b
1 00009008 fffffffc
1 0000900c 00000001
1 00009010 00000094
1 00009014 00000001
2 00000000 00000002
// Test 2: loads at each byte offset of a data word
0 00009040 8765f0a1
0 00008000 000090b7
0 00008004 04008103
0 00008008 0020a023
0 0000800c 0410c183
0 00008010 0030a223
0 00008014 04208203
0 00008018 0040a423
0 0000801c 04209283
0 00008020 0050a623
0 00008024 0400d303
0 00008028 0060a823
0 0000802c 0400a383
0 00008030 0070aa23
0 00008034 0430c403
0 00008038 0080ac23
0 0000803c 00100073
1 00009000 ffffffa1
1 00009004 000000f0
1 00009008 00000065
1 0000900c ffff8765
1 00009010 0000f0a1
1 00009014 8765f0a1
1 00009018 00000087
2 00000000 00000000
// Test 3: x0, branches taken and not taken, JAL, JALR, AUIPC, LUI
0 00008000 000090b7
0 00008004 00500113
0 00008008 ffd00193
0 0000800c 04d00013
0 00008010 0000a023
0 00008014 00210463
0 00008018 0020a223
0 0000801c 00310463
0 00008020 0020a423
0 00008024 00311463
0 00008028 0020a623
0 0000802c 00211463
0 00008030 0020a823
0 00008034 0021c463
0 00008038 0020aa23
0 0000803c 00314463
0 00008040 0020ac23
0 00008044 00315463
0 00008048 0020ae23
0 0000804c 0021d463
0 00008050 0220a023
0 00008054 00316463
0 00008058 0220a223
0 0000805c 0021e463
0 00008060 0220a423
0 00008064 0021f463
0 00008068 0220a623
0 0000806c 00317463
0 00008070 0220a823
0 00008074 008002ef
0 00008078 0220aa23
0 0000807c 0250ac23
0 00008080 00000317
0 00008084 011303e7
0 00008088 0220ae23
0 0000808c 0420a023
0 00008090 0470a023
0 00008094 0460a223
0 00008098 abcde437
0 0000809c 0480a423
0 000080a0 00100073
1 00009000 00000000
1 00009008 00000005
1 00009010 00000005
1 00009018 00000005
1 00009020 00000005
1 00009028 00000005
1 00009030 00000005
1 00009038 00008078
1 00009040 00008088
1 00009044 00008080
1 00009048 abcde000
2 00000000 0000000a
